/* src/ifu_pkg.sv */
`default_nettype none

package ifu_pkg;

    // Datapath and buffer geometry
    localparam int XLEN        = 32;
    localparam int FETCH_WIDTH = 2;
    localparam int IB_DEPTH    = 8;
    localparam int IB_PTR_W    = $clog2(IB_DEPTH);
    localparam int BLOCK_BYTES = FETCH_WIDTH * 4;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // Major opcodes, LoongArch32 encoding
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;

    // Counts 0..FETCH_WIDTH, used for pops and credit returns
    typedef logic [$clog2(FETCH_WIDTH + 1)-1:0] cnt_t;

    // 3R format
    typedef struct packed {
        logic [16:0] opcode17;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    // 2RI12 format
    typedef struct packed {
        logic [9:0]  opcode10;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    // One instruction word, read in either format
    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
    } instr_word_u;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } icache_req_t;

    // instr[0] belongs to the request pc, instr[1] to pc+4
    typedef struct packed {
        logic                              valid;
        instr_word_u [FETCH_WIDTH-1:0]     instr;
    } icache_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_word_u     instr;
    } ib_entry_t;

    // Lane 0 is the oldest entry
    typedef struct packed {
        logic [FETCH_WIDTH-1:0]      valid;
        ib_entry_t [FETCH_WIDTH-1:0] entry;
    } ib_head_t;

    typedef enum logic [1:0] {
        OP_ADD_W,
        OP_ADDI_W,
        OP_ILLEGAL
    } op_kind_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        op_kind_e        op;
        logic [4:0]      rd;
        logic [4:0]      rj;
        logic [4:0]      rk;
        logic [XLEN-1:0] imm;
    } decoded_t;

endpackage

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  ifu_pkg::redirect_t                            redirect_i,
    output ifu_pkg::icache_req_t                          icache_req_o,
    input  ifu_pkg::icache_rsp_t                          icache_rsp_i,
    output logic                                          ib_push_o,
    output ifu_pkg::ib_entry_t [ifu_pkg::FETCH_WIDTH-1:0] ib_push_block_o,
    input  ifu_pkg::cnt_t                                 credit_return_i
);
    import ifu_pkg::*;

    // Credits range over 0..IB_DEPTH
    logic [IB_PTR_W:0] credits_q;
    logic [IB_PTR_W:0] credits_n;
    logic [XLEN-1:0]   fetch_pc_q;
    logic [XLEN-1:0]   fetch_pc_n;
    logic              pending_q;
    logic              pending_n;
    logic              drop_q;
    logic              drop_n;
    logic              req_valid_q;
    logic [XLEN-1:0]   req_pc_q;
    logic              issue;

    // State as it would be after this edge, before a new request is counted
    always_comb begin
        pending_n = pending_q && !icache_rsp_i.valid;
        if (redirect_i.valid) begin
            // Old path is gone, buffer is emptied in the same cycle
            credits_n  = (IB_PTR_W + 1)'(IB_DEPTH);
            fetch_pc_n = redirect_i.pc & ~XLEN'(BLOCK_BYTES - 1);
            drop_n     = pending_n;
        end else begin
            credits_n  = credits_q + (IB_PTR_W + 1)'(credit_return_i);
            fetch_pc_n = fetch_pc_q;
            drop_n     = drop_q && !icache_rsp_i.valid;
        end
        issue = !pending_n && (credits_n >= (IB_PTR_W + 1)'(FETCH_WIDTH));
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credits_q   <= (IB_PTR_W + 1)'(IB_DEPTH);
            fetch_pc_q  <= RESET_PC;
            pending_q   <= 1'b0;
            drop_q      <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= issue;
            pending_q   <= pending_n || issue;
            drop_q      <= drop_n;
            if (issue) begin
                credits_q  <= credits_n - (IB_PTR_W + 1)'(FETCH_WIDTH);
                fetch_pc_q <= fetch_pc_n + XLEN'(BLOCK_BYTES);
            end else begin
                credits_q  <= credits_n;
                fetch_pc_q <= fetch_pc_n;
            end
        end
    end

    // PC of the outstanding request
    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc_q <= fetch_pc_n;
        end
    end

    // Request is a single-cycle pulse
    assign icache_req_o.valid = req_valid_q;
    assign icache_req_o.pc    = req_pc_q;

    // Stale responses and those racing a redirect never reach the buffer
    assign ib_push_o = icache_rsp_i.valid && !drop_q && !redirect_i.valid;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            ib_push_block_o[i].pc    = req_pc_q + XLEN'(i * (BLOCK_BYTES / FETCH_WIDTH));
            ib_push_block_o[i].instr = icache_rsp_i.instr[i];
        end
    end

endmodule

`default_nettype wire

/* src/instr_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_buffer (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic                                          flush_i,
    input  logic                                          push_i,
    input  ifu_pkg::ib_entry_t [ifu_pkg::FETCH_WIDTH-1:0] push_block_i,
    output ifu_pkg::ib_head_t                             head_o,
    input  ifu_pkg::cnt_t                                 pop_i,
    output ifu_pkg::cnt_t                                 credit_return_o
);
    import ifu_pkg::*;

    ib_entry_t           mem_q [IB_DEPTH];
    logic [IB_PTR_W-1:0] wr_ptr_q;
    logic [IB_PTR_W-1:0] rd_ptr_q;
    // Occupancy needs one bit more than the pointers
    logic [IB_PTR_W:0]   count_q;
    logic [IB_PTR_W:0]   push_cnt;
    logic [IB_PTR_W:0]   pop_cnt;

    assign push_cnt = push_i ? (IB_PTR_W + 1)'(FETCH_WIDTH) : '0;
    assign pop_cnt  = (IB_PTR_W + 1)'(pop_i);

    // Storage, a full block per push
    always_ff @(posedge clk) begin
        if (push_i) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                mem_q[wr_ptr_q + IB_PTR_W'(i)] <= push_block_i[i];
            end
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + IB_PTR_W'(FETCH_WIDTH);
            end
            rd_ptr_q <= rd_ptr_q + IB_PTR_W'(pop_i);
            count_q  <= count_q + push_cnt - pop_cnt;
        end
    end

    // Slots freed this cycle go back to fetch on the next one
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            credit_return_o <= '0;
        end else begin
            credit_return_o <= pop_i;
        end
    end

    // Two oldest entries, lane 0 first
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            head_o.valid[i] = count_q > (IB_PTR_W + 1)'(i);
            head_o.entry[i] = mem_q[rd_ptr_q + IB_PTR_W'(i)];
        end
    end

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,
    input  ifu_pkg::ib_head_t                            head_i,
    output ifu_pkg::cnt_t                                pop_o,
    output ifu_pkg::decoded_t [ifu_pkg::FETCH_WIDTH-1:0] decoded_o,
    input  logic                                         dispatch_ready_i
);
    import ifu_pkg::*;

    decoded_t [FETCH_WIDTH-1:0] out_q;
    decoded_t [FETCH_WIDTH-1:0] dec_d;
    logic                       out_busy;
    logic                       load;
    cnt_t                       head_cnt;

    // ADD.W first, then ADDI.W, anything else is illegal
    function automatic decoded_t decode_lane(input ib_entry_t entry, input logic valid);
        decoded_t d;
        d       = '0;
        d.valid = valid;
        d.pc    = entry.pc;
        d.op    = OP_ILLEGAL;
        if (entry.instr.r3.opcode17 == OPC_ADD_W) begin
            d.op = OP_ADD_W;
            d.rd = entry.instr.r3.rd;
            d.rj = entry.instr.r3.rj;
            d.rk = entry.instr.r3.rk;
        end else if (entry.instr.ri12.opcode10 == OPC_ADDI_W) begin
            d.op  = OP_ADDI_W;
            d.rd  = entry.instr.ri12.rd;
            d.rj  = entry.instr.ri12.rj;
            d.imm = {{(XLEN - 12){entry.instr.ri12.imm12[11]}}, entry.instr.ri12.imm12};
        end
        return d;
    endfunction

    always_comb begin
        out_busy = 1'b0;
        head_cnt = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (out_q[i].valid) begin
                out_busy = 1'b1;
            end
            if (head_i.valid[i]) begin
                head_cnt = head_cnt + cnt_t'(1);
            end
            dec_d[i] = decode_lane(head_i.entry[i], head_i.valid[i]);
        end
    end

    // Register takes new work when empty or being drained this cycle
    assign load  = !out_busy || dispatch_ready_i;
    assign pop_o = load ? head_cnt : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                out_q[i].valid <= 1'b0;
            end
        end else if (load) begin
            out_q <= dec_d;
        end
    end

    assign decoded_o = out_q;

endmodule

`default_nettype wire

/* src/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  ifu_pkg::redirect_t                           redirect_i,
    output ifu_pkg::icache_req_t                         icache_req_o,
    input  ifu_pkg::icache_rsp_t                         icache_rsp_i,
    output ifu_pkg::decoded_t [ifu_pkg::FETCH_WIDTH-1:0] decoded_o,
    input  logic                                         dispatch_ready_i
);
    import ifu_pkg::*;

    // Fetch to buffer
    logic                        ib_push;
    ib_entry_t [FETCH_WIDTH-1:0] ib_push_block;
    cnt_t                        credit_return;

    // Buffer to decoder
    ib_head_t                    ib_head;
    cnt_t                        ib_pop;

    fetch_unit u_fetch_unit (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect_i),
        .icache_req_o    (icache_req_o),
        .icache_rsp_i    (icache_rsp_i),
        .ib_push_o       (ib_push),
        .ib_push_block_o (ib_push_block),
        .credit_return_i (credit_return)
    );

    instr_buffer u_instr_buffer (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (redirect_i.valid),
        .push_i          (ib_push),
        .push_block_i    (ib_push_block),
        .head_o          (ib_head),
        .pop_i           (ib_pop),
        .credit_return_o (credit_return)
    );

    instr_decoder u_instr_decoder (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (redirect_i.valid),
        .head_i           (ib_head),
        .pop_o            (ib_pop),
        .decoded_o        (decoded_o),
        .dispatch_ready_i (dispatch_ready_i)
    );

endmodule

`default_nettype wire

/* testbench/tb_frontend_tasks.svh */
// Spreads the whole pc over the table index
function automatic int table_index(input logic [XLEN-1:0] pc);
    logic [7:0] h;
    h = pc[9:2] ^ pc[17:10] ^ pc[25:18] ^ {2'b00, pc[31:26]} ^ {6'b0, pc[1:0]};
    return int'(h);
endfunction

// ADD.W, ADDI.W with either immediate sign, then words no rule matches
task automatic fill_instr_table();
    logic [31:0] r;
    for (int i = 0; i < 256; i++) begin
        r = $random(seed);
        case (i % 4)
            0:       itable[i] = {OPC_ADD_W, r[14:0]};
            1:       itable[i] = {OPC_ADDI_W, 1'b0, r[20:0]};
            2:       itable[i] = {OPC_ADDI_W, 1'b1, r[20:0]};
            default: itable[i] = {6'h3f, r[25:0]};
        endcase
    end
endtask

// Decode straight from the LoongArch bit positions
function automatic decoded_t ref_decode(input logic [31:0] word, input logic [XLEN-1:0] pc);
    decoded_t d;
    d       = '0;
    d.valid = 1'b1;
    d.pc    = pc;
    d.op    = OP_ILLEGAL;
    if (word[31:15] == OPC_ADD_W) begin
        d.op = OP_ADD_W;
        d.rk = word[14:10];
        d.rj = word[9:5];
        d.rd = word[4:0];
    end else if (word[31:22] == OPC_ADDI_W) begin
        d.op  = OP_ADDI_W;
        d.rj  = word[9:5];
        d.rd  = word[4:0];
        d.imm = {{20{word[21]}}, word[21:10]};
    end
    return d;
endfunction

task automatic compare_decoded(input string name, input decoded_t want, input decoded_t got);
    if (got !== want) begin
        $display("error: time %0t %s expected %h got %h", $time, name, want, got);
        report_failure();
    end
endtask

task automatic compare_pc(input string name, input logic [XLEN-1:0] want,
                          input logic [XLEN-1:0] got);
    if (got !== want) begin
        $display("error: time %0t %s expected %h got %h", $time, name, want, got);
        report_failure();
    end
endtask

task automatic compare_bit(input string name, input logic want, input logic got);
    if (got !== want) begin
        $display("error: time %0t %s expected %b got %b", $time, name, want, got);
        report_failure();
    end
endtask

task automatic check_single_request();
    if (icache_req_o.valid) begin
        $display("fetch request to %h issued while another one was outstanding",
                 icache_req_o.pc);
        report_failure();
    end
endtask

task automatic check_output(input int lane);
    decoded_t want;
    if (exp_q.size() == 0) begin
        $display("decoded_o[%0d] with pc %h appeared while nothing was expected",
                 lane, decoded_o[lane].pc);
        report_failure();
    end else begin
        want = exp_q.pop_front();
        compare_decoded($sformatf("decoded_o[%0d]", lane), want, decoded_o[lane]);
        accepted++;
        case (want.op)
            OP_ADD_W:  op_seen[0]++;
            OP_ADDI_W: op_seen[want.imm[XLEN-1] ? 2 : 1]++;
            default:   op_seen[3]++;
        endcase
    end
endtask

// Latency of 1 to 4 cycles, response dropped if a redirect overtook it
task automatic serve_request();
    logic [XLEN-1:0] pc;
    int              req_epoch;
    int              delay;
    bit              keep;
    pc        = icache_req_o.pc;
    req_epoch = epoch;
    delay     = 1 + ($unsigned($random(seed)) % 4);
    req_pcs.push_back(pc);
    @(posedge clk);
    for (int i = 1; i < delay; i++) begin
        @(negedge clk);
        check_single_request();
        @(posedge clk);
    end
    #1;
    icache_rsp_i.valid    = 1'b1;
    icache_rsp_i.instr[0] = itable[table_index(pc)];
    icache_rsp_i.instr[1] = itable[table_index(pc + 4)];
    @(negedge clk);
    check_single_request();
    keep = !redirect_i.valid && (req_epoch == epoch);
    @(posedge clk);
    #1;
    icache_rsp_i.valid = 1'b0;
    if (keep) begin
        exp_q.push_back(ref_decode(itable[table_index(pc)], pc));
        exp_q.push_back(ref_decode(itable[table_index(pc + 4)], pc + 4));
    end
endtask

// Counts either logged requests or accepted instructions
task automatic wait_for(input bit on_requests, input int target, input int limit,
                        input string what);
    int c;
    int now;
    c   = 0;
    now = on_requests ? req_pcs.size() : accepted;
    while (now < target) begin
        if (c == limit) begin
            $display("timeout: %s did not happen within %0d cycles", what, limit);
            report_failure();
        end else begin
            @(posedge clk);
            c++;
            now = on_requests ? req_pcs.size() : accepted;
        end
    end
endtask

/* testbench/tb_frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frontend_top;
    import ifu_pkg::*;

    logic                       clk;
    logic                       rst_n_i;
    redirect_t                  redirect_i;
    icache_req_t                icache_req_o;
    icache_rsp_t                icache_rsp_i;
    decoded_t [FETCH_WIDTH-1:0] decoded_o;
    logic                       dispatch_ready_i;

    integer          seed = 32'h904f_f046;
    logic [XLEN-1:0] itable [256];
    logic [XLEN-1:0] req_pcs [$];
    decoded_t        exp_q [$];
    int              epoch;
    int              accepted;
    // ADD.W, ADDI.W positive, ADDI.W negative, illegal
    int              op_seen [4];

    always #20 clk = ~clk;

    frontend_top i_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_i       (redirect_i),
        .icache_req_o     (icache_req_o),
        .icache_rsp_i     (icache_rsp_i),
        .decoded_o        (decoded_o),
        .dispatch_ready_i (dispatch_ready_i)
    );

    // Cache responder, one request at a time
    always begin
        @(negedge clk);
        if (rst_n_i && icache_req_o.valid) begin
            serve_request();
        end
    end

    // A slot counts when dispatch takes it and no redirect kills it
    always @(negedge clk) begin
        if (rst_n_i && !redirect_i.valid && dispatch_ready_i) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (decoded_o[i].valid) begin
                    check_output(i);
                end
            end
        end
    end

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "tb_frontend_tasks.svh"

    // Reset, then the first blocks must come in address order
    task automatic reset_and_fetch_in_order();
        repeat (16) @(posedge clk);
        #1;
        compare_bit("icache_req_o.valid", 1'b0, icache_req_o.valid);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            compare_bit($sformatf("decoded_o[%0d].valid", i), 1'b0, decoded_o[i].valid);
        end
        rst_n_i = 1'b1;
        wait_for(1'b1, 6, 60, "the first six fetch requests");
        for (int i = 0; i < 6; i++) begin
            compare_pc($sformatf("icache_req_o.pc #%0d", i),
                       RESET_PC + XLEN'(i * BLOCK_BYTES), req_pcs[i]);
        end
    endtask

    // Every kind of word must have passed the scoreboard
    task automatic decode_mixed_formats();
        int start;
        start = accepted;
        wait_for(1'b0, start + 64, 500, "64 decoded instructions");
        for (int k = 0; k < 4; k++) begin
            if (op_seen[k] == 0) begin
                $display("no decoded instruction of kind %0d was seen", k);
                report_failure();
            end
        end
    endtask

    task automatic stall_dispatch();
        int held;
        int start;
        @(posedge clk);
        #1;
        dispatch_ready_i = 1'b0;
        repeat (30) @(posedge clk);
        // Fetched or in flight, not yet taken by dispatch
        held = req_pcs.size() * FETCH_WIDTH - accepted;
        if (held > (IB_DEPTH / FETCH_WIDTH + 1) * FETCH_WIDTH) begin
            $display("fetch ran ahead by %0d instructions while dispatch was stalled", held);
            report_failure();
        end
        #1;
        dispatch_ready_i = 1'b1;
        start = accepted;
        wait_for(1'b0, start + 40, 400, "40 instructions after the stall");
    endtask

    task automatic flush_on_redirect();
        logic [XLEN-1:0] target;
        int              n;
        int              start;
        target = 32'h1c00_0a36;
        // Lands in the cycle after a request, so that one is still outstanding
        wait_for(1'b1, req_pcs.size() + 1, 20, "a fetch request before the redirect");
        #1;
        n                = req_pcs.size();
        redirect_i.valid = 1'b1;
        redirect_i.pc    = target;
        @(posedge clk);
        #1;
        redirect_i = '0;
        // Old path is gone from here on
        epoch++;
        exp_q.delete();
        @(negedge clk);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            compare_bit($sformatf("decoded_o[%0d].valid", i), 1'b0, decoded_o[i].valid);
        end
        wait_for(1'b1, n + 1, 20, "the first fetch request after the redirect");
        compare_pc("icache_req_o.pc", {target[XLEN-1:3], 3'b000}, req_pcs[n]);
        start = accepted;
        wait_for(1'b0, start + 32, 300, "32 instructions after the redirect");
    endtask

    task automatic toggle_ready_randomly();
        logic [31:0] r;
        int          start;
        int          c;
        start = accepted;
        c     = 0;
        while (accepted < start + 200) begin
            if (c == 2000) begin
                $display("timeout: 200 instructions were not accepted within 2000 cycles");
                report_failure();
            end else begin
                @(posedge clk);
                #1;
                r                = $random(seed);
                dispatch_ready_i = r[0];
                c++;
            end
        end
    endtask

    initial begin
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        redirect_i       = '0;
        icache_rsp_i     = '0;
        dispatch_ready_i = 1'b1;
        fill_instr_table();
        reset_and_fetch_in_order();
        decode_mixed_formats();
        stall_dispatch();
        flush_on_redirect();
        toggle_ready_randomly();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+testbench
src/ifu_pkg.sv
src/fetch_unit.sv
src/instr_buffer.sv
src/instr_decoder.sv
src/frontend_top.sv
testbench/tb_frontend_top.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - files:
      - src/ifu_pkg.sv
      - src/fetch_unit.sv
      - src/instr_buffer.sv
      - src/instr_decoder.sv
      - src/frontend_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_frontend_top.sv
